/* logic/axi_burst_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_burst_mem (
	input  logic                clk,
	input  logic                rst,
	input  logic                ar_valid,
	input  dcache_pkg::axi_ar_t ar,
	output logic                ar_ready,
	output logic                r_valid,
	output dcache_pkg::axi_r_t  r,
	input  logic                r_ready,
	input  logic                mem_wr_valid,
	input  dcache_pkg::mem_wr_t mem_wr
);
	import dcache_pkg::*;

	logic [BEAT_W-1:0]            mem [MEM_WORDS];
	logic                         bursting;
	logic                         incr;
	logic [7:0]                   remaining;
	logic [$clog2(MEM_WORDS)-1:0] rd_idx;
	logic [$clog2(MEM_WORDS)-1:0] wr_lo;
	logic [$clog2(MEM_WORDS)-1:0] wr_hi;

	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	assign ar_ready = !bursting;

	always_ff @(posedge clk) begin
		if (rst) begin
			bursting <= 1'b0;
		end else if (!bursting) begin
			if (ar_valid) begin
				bursting <= 1'b1;
			end
		end else if (r_ready && remaining == 8'd0) begin
			bursting <= 1'b0;
		end
	end

	// beat address and count, fixed bursts hold the address
	always_ff @(posedge clk) begin
		if (!bursting) begin
			rd_idx    <= ar.araddr[2 +: $clog2(MEM_WORDS)];
			remaining <= ar.arlen;
			incr      <= ar.arburst == 2'b01;
		end else if (r_ready) begin
			remaining <= remaining - 8'd1;
			if (incr) begin
				rd_idx <= rd_idx + 1'b1;
			end
		end
	end

	assign r_valid = bursting;

	always_comb begin
		r.rdata = mem[rd_idx];
		r.rresp = 2'b00;
		r.rlast = remaining == 8'd0;
	end

	// a 64-bit write covers an aligned pair of beats
	assign wr_lo = {mem_wr.addr[3 +: $clog2(MEM_WORDS) - 1], 1'b0};
	assign wr_hi = {mem_wr.addr[3 +: $clog2(MEM_WORDS) - 1], 1'b1};

	always_ff @(posedge clk) begin
		if (mem_wr_valid) begin
			mem[wr_lo] <= (mem[wr_lo] & ~mem_wr.mask[BEAT_W-1:0])
				| (mem_wr.data[BEAT_W-1:0] & mem_wr.mask[BEAT_W-1:0]);
			mem[wr_hi] <= (mem[wr_hi] & ~mem_wr.mask[DATA_W-1:BEAT_W])
				| (mem_wr.data[DATA_W-1:BEAT_W] & mem_wr.mask[DATA_W-1:BEAT_W]);
		end
	end

endmodule

`default_nettype wire

/* logic/dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          req_valid,
	input  dcache_pkg::cache_req_t        req,
	output logic                          ready,
	output logic [dcache_pkg::DATA_W-1:0] rdata,
	output logic                          ar_valid,
	output dcache_pkg::axi_ar_t           ar,
	input  logic                          ar_ready,
	input  logic                          r_valid,
	input  dcache_pkg::axi_r_t            r,
	output logic                          r_ready,
	output logic                          mem_wr_valid,
	output dcache_pkg::mem_wr_t           mem_wr
);
	import dcache_pkg::*;

	logic               accept;
	logic               rd_hit;
	logic               miss;
	logic               wr_req;
	logic [WAYS-1:0]    hit_way;
	logic               busy;
	logic               beat_we;
	logic [WAYS-1:0]    beat_way;
	logic [3:0]         beat_idx;
	logic               done;
	logic [WAYS-1:0]    ram_en;
	logic [5:0]         ram_entry;
	logic [ENTRY_W-1:0] ram_bit_en;
	logic [ENTRY_W-1:0] ram_wdata;
	logic [ENTRY_W-1:0] ram_rdata [WAYS];
	logic [WAYS-1:0]    way_q;
	logic [ENTRY_W-1:0] line_sel;

	// no new request while a response is out or a fill runs
	assign accept = req_valid && !ready && !busy;
	assign rd_hit = accept && !req.wren && (|hit_way);
	assign miss   = accept && !req.wren && !(|hit_way);
	assign wr_req = accept && req.wren;

	dcache_tags tags_i (
		.clk         (clk),
		.rst         (rst),
		.lookup_addr (req.addr),
		.hit_way     (hit_way),
		.install     (done),
		.install_way (beat_way),
		.inval       (wr_req)
	);

	dcache_refill refill_i (
		.clk       (clk),
		.rst       (rst),
		.miss      (miss),
		.line_addr (req.addr),
		.ar_valid  (ar_valid),
		.ar        (ar),
		.ar_ready  (ar_ready),
		.r_valid   (r_valid),
		.r         (r),
		.busy      (busy),
		.beat_we   (beat_we),
		.beat_way  (beat_way),
		.beat_idx  (beat_idx),
		.done      (done)
	);

	// fill beats go to their 32-bit lane of entry {set, beat_idx[3:2]}
	assign ram_entry  = busy ? {req.addr[9:6], beat_idx[3:2]} : req.addr[9:4];
	assign ram_bit_en = ENTRY_W'({BEAT_W{1'b1}}) << (BEAT_W * beat_idx[1:0]);
	assign ram_wdata  = {(ENTRY_W / BEAT_W){r.rdata}};

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			ram_en[w] = busy ? (beat_we && beat_way[w]) : (rd_hit && hit_way[w]);
		end
	end

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		dcache_data_ram ram_i (
			.clk    (clk),
			.en     (ram_en[w]),
			.we     (beat_we),
			.bit_en (ram_bit_en),
			.entry  (ram_entry),
			.wdata  (ram_wdata),
			.rdata  (ram_rdata[w])
		);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
			way_q <= '0;
		end else begin
			ready <= rd_hit || wr_req;
			way_q <= rd_hit ? hit_way : '0;
		end
	end

	always_comb begin
		line_sel = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (way_q[w]) begin
				line_sel = line_sel | ram_rdata[w];
			end
		end
	end

	// addr bit 3 picks the 64-bit half
	assign rdata = req.addr[3] ? line_sel[ENTRY_W-1 -: DATA_W] : line_sel[DATA_W-1:0];

	assign r_ready      = 1'b1;
	assign mem_wr_valid = wr_req;

	always_comb begin
		mem_wr.addr = req.addr;
		mem_wr.data = req.din;
		mem_wr.mask = req.mask;
	end

endmodule

`default_nettype wire

/* logic/dcache_data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_data_ram (
	input  logic                           clk,
	input  logic                           en,
	input  logic                           we,
	input  logic [dcache_pkg::ENTRY_W-1:0] bit_en,
	input  logic [5:0]                     entry,
	input  logic [dcache_pkg::ENTRY_W-1:0] wdata,
	output logic [dcache_pkg::ENTRY_W-1:0] rdata
);
	import dcache_pkg::*;

	logic [ENTRY_W-1:0] mem [RAM_DEPTH];

	// single port, read data registered
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[entry] <= (mem[entry] & ~bit_en) | (wdata & bit_en);
			end else begin
				rdata <= mem[entry];
			end
		end
	end

endmodule

`default_nettype wire

/* logic/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

	// cache geometry
	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 64;
	localparam int BEAT_W    = 32;
	localparam int WAYS      = 4;
	localparam int SETS      = 16;
	localparam int TAG_W     = 22;
	localparam int ENTRY_W   = 128;
	localparam int RAM_DEPTH = 64;

	// sixteen beats per line fill
	localparam logic [7:0] BURST_LEN = 8'd15;

	// backing store size in beats, addresses wrap
	localparam int MEM_WORDS = 4096;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              wren;
		logic [DATA_W-1:0] din;
		logic [DATA_W-1:0] mask;
	} cache_req_t;

	typedef struct packed {
		logic [ADDR_W-1:0] araddr;
		logic [7:0]        arlen;
		logic [2:0]        arsize;
		logic [1:0]        arburst;
	} axi_ar_t;

	typedef struct packed {
		logic [BEAT_W-1:0] rdata;
		logic [1:0]        rresp;
		logic              rlast;
	} axi_r_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [DATA_W-1:0] mask;
	} mem_wr_t;

endpackage

`default_nettype wire

/* logic/dcache_refill.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_refill (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          miss,
	input  logic [dcache_pkg::ADDR_W-1:0] line_addr,
	output logic                          ar_valid,
	output dcache_pkg::axi_ar_t           ar,
	input  logic                          ar_ready,
	input  logic                          r_valid,
	input  dcache_pkg::axi_r_t            r,
	output logic                          busy,
	output logic                          beat_we,
	output logic [dcache_pkg::WAYS-1:0]   beat_way,
	output logic [3:0]                    beat_idx,
	output logic                          done
);
	import dcache_pkg::*;

	// state: 0 idle, 1 refill
	logic            refill_q;
	logic            refill_d;
	logic [3:0]      beat_cnt;
	logic [WAYS-1:0] victim;
	logic            beat_fire;

	assign beat_fire = refill_q && r_valid;

	// read address only offered from idle
	assign ar_valid = !refill_q && miss;

	always_comb begin
		ar.araddr  = {line_addr[ADDR_W-1:6], 6'b0};
		ar.arlen   = BURST_LEN;
		ar.arsize  = 3'($clog2(BEAT_W / 8));
		ar.arburst = 2'b01;
	end

	always_comb begin
		refill_d = refill_q;
		if (!refill_q) begin
			if (miss && ar_ready) begin
				refill_d = 1'b1;
			end
		end else if (r_valid && r.rlast) begin
			refill_d = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			refill_q <= 1'b0;
			beat_cnt <= 4'd0;
		end else begin
			refill_q <= refill_d;
			if (!refill_q) begin
				beat_cnt <= 4'd0;
			end else if (beat_fire) begin
				beat_cnt <= beat_cnt + 4'd1;
			end
		end
	end

	// rotating one-hot victim, held for the whole fill
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= WAYS'(1);
		end else if (!refill_q) begin
			victim <= {victim[WAYS-2:0], victim[WAYS-1]};
		end
	end

	assign busy     = refill_q;
	assign beat_we  = beat_fire;
	assign beat_way = victim;
	assign beat_idx = beat_cnt;
	assign done     = beat_fire && r.rlast;

endmodule

`default_nettype wire

/* logic/dcache_tags.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tags (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [dcache_pkg::ADDR_W-1:0] lookup_addr,
	output logic [dcache_pkg::WAYS-1:0]   hit_way,
	input  logic                          install,
	input  logic [dcache_pkg::WAYS-1:0]   install_way,
	input  logic                          inval
);
	import dcache_pkg::*;

	logic [TAG_W-1:0]         tag_mem [WAYS][SETS];
	logic [SETS-1:0]          valid   [WAYS];
	logic [$clog2(SETS)-1:0]  set_idx;
	logic [TAG_W-1:0]         lookup_tag;
	logic [WAYS-1:0]          tag_eq;

	// set index sits just above the 64-byte line offset
	assign set_idx    = lookup_addr[6 +: $clog2(SETS)];
	assign lookup_tag = lookup_addr[ADDR_W-1 -: TAG_W];

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			tag_eq[w]  = tag_mem[w][set_idx] == lookup_tag;
			hit_way[w] = valid[w][set_idx] && tag_eq[w];
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < WAYS; w++) begin
			if (install && install_way[w]) begin
				tag_mem[w][set_idx] <= lookup_tag;
			end
		end
	end

	// write-through drops any way holding the written line
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++) begin
				valid[w] <= '0;
			end
		end else begin
			for (int w = 0; w < WAYS; w++) begin
				if (install && install_way[w]) begin
					valid[w][set_idx] <= 1'b1;
				end else if (inval && tag_eq[w]) begin
					valid[w][set_idx] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          req_valid,
	input  dcache_pkg::cache_req_t        req,
	output logic                          ready,
	output logic [dcache_pkg::DATA_W-1:0] rdata
);
	import dcache_pkg::*;

	logic    ar_valid;
	axi_ar_t ar;
	logic    ar_ready;
	logic    r_valid;
	axi_r_t  r;
	logic    r_ready;
	logic    mem_wr_valid;
	mem_wr_t mem_wr;

	dcache dcache_i (
		.clk          (clk),
		.rst          (rst),
		.req_valid    (req_valid),
		.req          (req),
		.ready        (ready),
		.rdata        (rdata),
		.ar_valid     (ar_valid),
		.ar           (ar),
		.ar_ready     (ar_ready),
		.r_valid      (r_valid),
		.r            (r),
		.r_ready      (r_ready),
		.mem_wr_valid (mem_wr_valid),
		.mem_wr       (mem_wr)
	);

	// backing store with burst reads and write-through port
	axi_burst_mem mem_i (
		.clk          (clk),
		.rst          (rst),
		.ar_valid     (ar_valid),
		.ar           (ar),
		.ar_ready     (ar_ready),
		.r_valid      (r_valid),
		.r            (r),
		.r_ready      (r_ready),
		.mem_wr_valid (mem_wr_valid),
		.mem_wr       (mem_wr)
	);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module dcache_tb \
	--Mdir obj_dir -o dcache_sim

./obj_dir/dcache_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log; then
	exit 0
fi
exit 1

/* tb/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
	import dcache_pkg::*;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} read_result_t;

	localparam int TIMEOUT     = 200;
	localparam int MODEL_WORDS = MEM_WORDS / 2;

	logic              clk;
	logic              rst;
	logic              req_valid;
	cache_req_t        req;
	logic              ready;
	logic [DATA_W-1:0] rdata;

	// 64-bit view of the backing store
	logic [DATA_W-1:0] model_mem [MODEL_WORDS];
	read_result_t      pending [$];
	integer            seed;

	dcache_top dcache_top_i (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.ready     (ready),
		.rdata     (rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// memory wraps at its size, same as the backing store
	function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
		return model_mem[addr[3 +: $clog2(MODEL_WORDS)]];
	endfunction

	task automatic check_rdata(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("** Error: rdata at addr %h: got %h, expected %h", addr, got, exp);
			$display("Regression failed");
			$fatal(1, "read data mismatch");
		end
	endtask

	task automatic check_latency(input cache_req_t rq, input int cycles);
		if (cycles != 1) begin
			$display("** Error: ready latency for %s at addr %h: got %h, expected %h",
				rq.wren ? "write" : "read", rq.addr, cycles, 1);
			$display("Regression failed");
			$fatal(1, "ready latency mismatch");
		end
	endtask

	// present one request and hold it until ready
	task automatic issue(input cache_req_t rq, output int cycles,
			output logic [DATA_W-1:0] data);
		@(negedge clk);
		req       = rq;
		req_valid = 1'b1;
		cycles    = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!ready && cycles < TIMEOUT);
		if (!ready) begin
			$display("timeout: no ready within %0d cycles for addr %h", TIMEOUT, rq.addr);
			$display("Regression failed");
			$fatal(1, "request timed out");
		end else begin
			data      = rdata;
			req_valid = 1'b0;
		end
	endtask

	task automatic do_read(input logic [ADDR_W-1:0] addr, input bit expect_hit);
		cache_req_t        rq;
		read_result_t      res;
		int                cycles;
		logic [DATA_W-1:0] data;
		rq      = '0;
		rq.addr = addr;
		issue(rq, cycles, data);
		if (expect_hit) begin
			check_latency(rq, cycles);
		end
		res.addr = addr;
		res.data = data;
		pending.push_back(res);
	endtask

	task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] din,
			input logic [DATA_W-1:0] mask);
		cache_req_t                     rq;
		int                             cycles;
		logic [DATA_W-1:0]              data;
		logic [$clog2(MODEL_WORDS)-1:0] idx;
		rq      = '0;
		rq.addr = addr;
		rq.wren = 1'b1;
		rq.din  = din;
		rq.mask = mask;
		issue(rq, cycles, data);
		check_latency(rq, cycles);
		idx            = addr[3 +: $clog2(MODEL_WORDS)];
		model_mem[idx] = (model_mem[idx] & ~mask) | (din & mask);
	endtask

	// reads are scored at the posedge after they finish
	always @(posedge clk) begin : compare_reads
		read_result_t res;
		while (pending.size() > 0) begin
			res = pending.pop_front();
			check_rdata(res.addr, res.data, expected_word(res.addr));
		end
	end

	initial begin : stimulus
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] din;
		logic [DATA_W-1:0] mask;
		int                drain;
		seed      = 32'h5d15;
		rst       = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		for (int i = 0; i < MODEL_WORDS; i++) begin
			model_mem[i] = '0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// untouched memory reads zero, then a masked merge
		do_read(32'h0000_0100, 1'b0);
		do_write(32'h0000_0100, 64'h1122_3344_5566_7788, 64'hffff_0000_ff00_00ff);
		do_read(32'h0000_0100, 1'b0);

		// filled line hits in one cycle
		do_read(32'h0000_0208, 1'b0);
		do_read(32'h0000_0208, 1'b1);
		do_read(32'h0000_0230, 1'b1);

		// write to a resident line must drop the stale copy
		do_read(32'h0000_0318, 1'b0);
		do_write(32'h0000_0318, 64'hdead_beef_cafe_f00d, 64'h0000_ffff_ffff_0000);
		do_read(32'h0000_0318, 1'b0);
		do_write(32'h0000_0318, 64'h0123_4567_89ab_cdef, 64'hff00_ff00_ff00_ff00);
		do_read(32'h0000_0318, 1'b0);

		// six lines in set 1, two more than the ways
		for (int k = 0; k < 6; k++) begin
			do_write(32'h48 + k * 32'h400, {32'hc0de_0000 + 32'(k), 32'h1000 + 32'(k)}, '1);
		end
		for (int k = 0; k < 6; k++) begin
			do_read(32'h48 + k * 32'h400, 1'b0);
		end
		for (int k = 0; k < 6; k++) begin
			do_read(32'h48 + k * 32'h400, 1'b0);
		end

		// random mix over the low 2 KB
		for (int n = 0; n < 400; n++) begin
			addr = $random(seed) & 32'h0000_07f8;
			if (($random(seed) & 1) != 0) begin
				din  = {$random(seed), $random(seed)};
				mask = {$random(seed), $random(seed)};
				do_write(addr, din, mask);
			end else begin
				do_read(addr, 1'b0);
			end
		end

		drain = 0;
		while (pending.size() > 0 && drain < TIMEOUT) begin
			@(negedge clk);
			drain++;
		end
		if (pending.size() == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("checker left %0d reads unscored", pending.size());
			$display("Regression failed");
			$fatal(1, "checker stalled");
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
logic/dcache_pkg.sv
logic/dcache_tags.sv
logic/dcache_data_ram.sv
logic/dcache_refill.sv
logic/dcache.sv
logic/axi_burst_mem.sv
logic/dcache_top.sv
tb/dcache_tb.sv
